// ==== filelist.f ====
src/rename_pkg.sv
src/rename_grp_if.sv
src/free_list.sv
src/rename_map.sv
src/rename_ctrl.sv
src/group_bypass.sv
src/rename_top.sv
tb/tb_rename_top.sv

// ==== src/free_list.sv ====
`timescale 1ns/1ps

module free_list
  import rename_pkg::*;
#(
  parameter rnid_t INIT_BASE = rnid_t'(FLIST_BASE)
) (
  input  logic  i_clk,
  input  logic  i_reset_n,
  input  logic  i_push,
  input  rnid_t i_push_id,
  input  logic  i_pop,
  output rnid_t o_pop_id,
  output logic  o_empty
);

  logic [FLIST_PTR_W-1:0] r_head;
  logic [FLIST_PTR_W-1:0] r_tail;
  logic [FLIST_PTR_W:0]   r_count;   // one extra bit to tell full from empty
  rnid_t                  r_list [FLIST_SIZE];

  function automatic logic [FLIST_PTR_W-1:0] ptr_inc(input logic [FLIST_PTR_W-1:0] ptr);
    if (ptr == FLIST_PTR_W'(FLIST_SIZE - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign o_pop_id = r_list[r_head];   // head is the next ID handed out
  assign o_empty  = (r_count == '0);

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      // queue starts full, ascending from the lane base
      for (int i = 0; i < FLIST_SIZE; i++) begin
        r_list[i] <= INIT_BASE + rnid_t'(i);
      end
      r_head  <= '0;
      r_tail  <= '0;
      r_count <= (FLIST_PTR_W + 1)'(FLIST_SIZE);
    end else begin
      if (i_push) begin
        r_list[r_tail] <= i_push_id;
        r_tail         <= ptr_inc(r_tail);
      end
      if (i_pop) begin
        r_head <= ptr_inc(r_head);
      end
      case ({i_push, i_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;   // both or neither, level unchanged
      endcase
    end
  end

endmodule

// ==== src/group_bypass.sv ====
`timescale 1ns/1ps

module group_bypass
  import rename_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset_n,
  rename_grp_if.sink        grp,
  input  logic              i_fire,
  input  rnid_t             i_rs1_rnid [DISP_SIZE],
  input  rnid_t             i_rs2_rnid [DISP_SIZE],
  input  rnid_t             i_old_rnid [DISP_SIZE],
  output logic              o_valid,
  output rnid_t             o_rd_rnid     [DISP_SIZE],
  output rnid_t             o_rd_old_rnid [DISP_SIZE],
  output rnid_t             o_rs1_rnid    [DISP_SIZE],
  output rnid_t             o_rs2_rnid    [DISP_SIZE]
);

  grp_t  w_wr;                  // lane produces a new mapping
  rnid_t w_rs1 [DISP_SIZE];
  rnid_t w_rs2 [DISP_SIZE];
  rnid_t w_old [DISP_SIZE];

  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_wr[d] = grp.valid[d] & grp.rd_valid[d] & (grp.rd_idx[d] != '0);
    end
  end

  // default to the map value, then let earlier lanes override
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_rs1[d] = i_rs1_rnid[d];
      w_rs2[d] = i_rs2_rnid[d];
      w_old[d] = i_old_rnid[d];
      // scan oldest to youngest, the last hit is the nearest producer
      for (int p = 0; p < d; p++) begin
        if (w_wr[p] && (grp.rd_idx[p] == grp.rs1_idx[d])) begin
          w_rs1[d] = grp.new_rnid[p];
        end
        if (w_wr[p] && (grp.rd_idx[p] == grp.rs2_idx[d])) begin
          w_rs2[d] = grp.new_rnid[p];
        end
        // old dest is the mapping an earlier lane just made
        if (w_wr[p] && (grp.rd_idx[p] == grp.rd_idx[d])) begin
          w_old[d] = grp.new_rnid[p];
        end
      end
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_fire;   // single-cycle strobe per accepted group
    end
  end

  // result payload, held between groups
  always_ff @(posedge i_clk) begin
    if (i_fire) begin
      for (int d = 0; d < DISP_SIZE; d++) begin
        o_rd_rnid[d]     <= grp.new_rnid[d];
        o_rd_old_rnid[d] <= w_old[d];
        o_rs1_rnid[d]    <= w_rs1[d];
        o_rs2_rnid[d]    <= w_rs2[d];
      end
    end
  end

endmodule

// ==== src/rename_ctrl.sv ====
`timescale 1ns/1ps

module rename_ctrl
  import rename_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset_n,
  input  logic              i_disp_valid,
  input  grp_t              i_empty,
  output logic              o_disp_ready,
  output logic              o_fire,
  output grp_t              o_pop,
  input  rnid_t             i_pop_id [DISP_SIZE],
  input  grp_t              i_cmt_valid,
  input  rnid_t             i_cmt_rnid [DISP_SIZE],
  output grp_t              o_push,
  output rnid_t             o_push_id [DISP_SIZE],
  rename_grp_if.ctrl        grp
);

  logic  r_live;                     // set one cycle after reset release
  grp_t  w_alloc;
  grp_t  r_cmt_valid;
  rnid_t r_cmt_rnid [DISP_SIZE];

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_live <= 1'b0;
    end else begin
      r_live <= 1'b1;
    end
  end

  // whole group waits until every lane can supply an ID
  assign o_disp_ready = r_live & ~(|i_empty);
  assign o_fire       = i_disp_valid & o_disp_ready;

  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_alloc[d] = grp.valid[d] & grp.rd_valid[d] & (grp.rd_idx[d] != '0);
      o_pop[d]   = o_fire & w_alloc[d];
      // x0 keeps its fixed ID, the head entry is left in place
      if (grp.rd_idx[d] == '0) begin
        grp.new_rnid[d] = X0_RNID;
      end else begin
        grp.new_rnid[d] = i_pop_id[d];
      end
    end
  end

  // commit return, one cycle behind the strobe
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_cmt_valid <= '0;
    end else begin
      r_cmt_valid <= i_cmt_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    r_cmt_rnid <= i_cmt_rnid;
  end

  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_push[d] = r_cmt_valid[d] & (r_cmt_rnid[d] != X0_RNID);   // ID 0 is never freed
    end
  end

  assign o_push_id = r_cmt_rnid;

endmodule

// ==== src/rename_grp_if.sv ====
`timescale 1ns/1ps

interface rename_grp_if import rename_pkg::*; ();

  grp_t  valid;                 // lane holds an instruction
  grp_t  rd_valid;              // lane writes a destination
  arch_t rd_idx   [DISP_SIZE];
  arch_t rs1_idx  [DISP_SIZE];
  arch_t rs2_idx  [DISP_SIZE];
  rnid_t new_rnid [DISP_SIZE];  // allocated ID, 0 for x0

  // producer side, fills in the allocated IDs
  modport ctrl (
    input  valid,
    input  rd_valid,
    input  rd_idx,
    input  rs1_idx,
    input  rs2_idx,
    output new_rnid
  );

  modport sink (
    input valid,
    input rd_valid,
    input rd_idx,
    input rs1_idx,
    input rs2_idx,
    input new_rnid
  );

endinterface

// ==== src/rename_map.sv ====
`timescale 1ns/1ps

module rename_map
  import rename_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_reset_n,
  rename_grp_if.sink        grp,
  input  logic              i_fire,
  output rnid_t             o_rs1_rnid [DISP_SIZE],
  output rnid_t             o_rs2_rnid [DISP_SIZE],
  output rnid_t             o_old_rnid [DISP_SIZE]
);

  rnid_t r_map [ARCH_REGS];
  grp_t  w_wr_en;

  // lookups see the map as it was before this group
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      o_rs1_rnid[d] = r_map[grp.rs1_idx[d]];
      o_rs2_rnid[d] = r_map[grp.rs2_idx[d]];
      o_old_rnid[d] = r_map[grp.rd_idx[d]];   // previous mapping of rd
    end
  end

  // x0 entry is never written, stays at ID 0
  always_comb begin
    for (int d = 0; d < DISP_SIZE; d++) begin
      w_wr_en[d] = i_fire & grp.valid[d] & grp.rd_valid[d] & (grp.rd_idx[d] != '0);
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      for (int i = 0; i < ARCH_REGS; i++) begin
        r_map[i] <= rnid_t'(i);   // identity mapping
      end
    end else begin
      // ascending lane order, so the youngest writer of a register wins
      for (int d = 0; d < DISP_SIZE; d++) begin
        if (w_wr_en[d]) begin
          r_map[grp.rd_idx[d]] <= grp.new_rnid[d];
        end
      end
    end
  end

endmodule

// ==== src/rename_pkg.sv ====
package rename_pkg;

  // dispatch group and register file sizes
  localparam int DISP_SIZE  = 2;
  localparam int ARCH_REGS  = 32;
  localparam int FLIST_SIZE = 16;   // entries per lane free list

  // every physical ID is either mapped or sitting in one lane's free list
  localparam int RNID_SIZE = ARCH_REGS + DISP_SIZE * FLIST_SIZE;
  localparam int RNID_W    = $clog2(RNID_SIZE);
  localparam int ARCH_W    = $clog2(ARCH_REGS);

  localparam int FLIST_PTR_W = $clog2(FLIST_SIZE);

  typedef logic [RNID_W-1:0]    rnid_t;
  typedef logic [ARCH_W-1:0]    arch_t;
  typedef logic [DISP_SIZE-1:0] grp_t;

  // reset state
  // map entry i holds ID i, so IDs below ARCH_REGS start out mapped.
  // lane d free list holds FLIST_BASE + FLIST_SIZE*d upward, in pop order.
  localparam int FLIST_BASE = ARCH_REGS;

  // x0 is pinned to ID 0, never allocated and never freed
  localparam rnid_t X0_RNID = '0;

endpackage

// ==== src/rename_top.sv ====
`timescale 1ns/1ps

module rename_top
  import rename_pkg::*;
(
  input  logic  i_clk,
  input  logic  i_reset_n,

  // dispatch group
  input  logic  i_disp_valid,
  output logic  o_disp_ready,
  input  grp_t  i_rd_valid,
  input  arch_t i_rd_idx  [DISP_SIZE],
  input  arch_t i_rs1_idx [DISP_SIZE],
  input  arch_t i_rs2_idx [DISP_SIZE],

  // renamed group, one cycle after fire
  output logic  o_valid,
  output rnid_t o_rd_rnid     [DISP_SIZE],
  output rnid_t o_rd_old_rnid [DISP_SIZE],
  output rnid_t o_rs1_rnid    [DISP_SIZE],
  output rnid_t o_rs2_rnid    [DISP_SIZE],

  // commit, old IDs back to the free lists
  input  grp_t  i_cmt_valid,
  input  rnid_t i_cmt_rnid [DISP_SIZE]
);

  logic  w_fire;
  grp_t  w_empty;
  grp_t  w_pop;
  grp_t  w_push;
  rnid_t w_pop_id  [DISP_SIZE];
  rnid_t w_push_id [DISP_SIZE];
  rnid_t w_rs1_map [DISP_SIZE];
  rnid_t w_rs2_map [DISP_SIZE];
  rnid_t w_old_map [DISP_SIZE];

  rename_grp_if u_grp ();

  // every lane of a presented group carries an instruction
  assign u_grp.valid    = {DISP_SIZE{i_disp_valid}};
  assign u_grp.rd_valid = i_rd_valid;
  assign u_grp.rd_idx   = i_rd_idx;
  assign u_grp.rs1_idx  = i_rs1_idx;
  assign u_grp.rs2_idx  = i_rs2_idx;

  rename_ctrl u_ctrl (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_disp_valid (i_disp_valid),
    .i_empty      (w_empty),
    .o_disp_ready (o_disp_ready),
    .o_fire       (w_fire),
    .o_pop        (w_pop),
    .i_pop_id     (w_pop_id),
    .i_cmt_valid  (i_cmt_valid),
    .i_cmt_rnid   (i_cmt_rnid),
    .o_push       (w_push),
    .o_push_id    (w_push_id),
    .grp          (u_grp)
  );

  generate
    for (genvar d = 0; d < DISP_SIZE; d++) begin : g_flist
      free_list #(
        .INIT_BASE (rnid_t'(FLIST_BASE + FLIST_SIZE * d))
      ) u_free_list (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_push    (w_push[d]),
        .i_push_id (w_push_id[d]),
        .i_pop     (w_pop[d]),
        .o_pop_id  (w_pop_id[d]),
        .o_empty   (w_empty[d])
      );
    end
  endgenerate

  rename_map u_map (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .grp        (u_grp),
    .i_fire     (w_fire),
    .o_rs1_rnid (w_rs1_map),
    .o_rs2_rnid (w_rs2_map),
    .o_old_rnid (w_old_map)
  );

  group_bypass u_bypass (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .grp           (u_grp),
    .i_fire        (w_fire),
    .i_rs1_rnid    (w_rs1_map),
    .i_rs2_rnid    (w_rs2_map),
    .i_old_rnid    (w_old_map),
    .o_valid       (o_valid),
    .o_rd_rnid     (o_rd_rnid),
    .o_rd_old_rnid (o_rd_old_rnid),
    .o_rs1_rnid    (o_rs1_rnid),
    .o_rs2_rnid    (o_rs2_rnid)
  );

endmodule

// ==== tb/tb_rename_top.sv ====
`timescale 1ns/1ps

module tb_rename_top
  import rename_pkg::*;
();

  localparam int NUM_GROUPS = 3000;
  localparam int TIMEOUT    = NUM_GROUPS * 4;   // in clock cycles

  logic  i_clk;
  logic  i_reset_n;
  logic  i_disp_valid;
  logic  o_disp_ready;
  grp_t  i_rd_valid;
  arch_t i_rd_idx  [DISP_SIZE];
  arch_t i_rs1_idx [DISP_SIZE];
  arch_t i_rs2_idx [DISP_SIZE];
  logic  o_valid;
  rnid_t o_rd_rnid     [DISP_SIZE];
  rnid_t o_rd_old_rnid [DISP_SIZE];
  rnid_t o_rs1_rnid    [DISP_SIZE];
  rnid_t o_rs2_rnid    [DISP_SIZE];
  grp_t  i_cmt_valid;
  rnid_t i_cmt_rnid [DISP_SIZE];

  // reference model state
  rnid_t model_map [ARCH_REGS];
  rnid_t free_q [DISP_SIZE][$];   // lane free lists popped from the front
  rnid_t pend_q [DISP_SIZE][$];   // displaced IDs waiting for commit
  grp_t  push_d1;                 // commit seen last cycle
  grp_t  push_d2;                 // commit two cycles back lands in the list now
  rnid_t push_id_d1 [DISP_SIZE];
  rnid_t push_id_d2 [DISP_SIZE];

  logic  exp_valid;
  grp_t  exp_chk_rd;              // lanes with a defined destination result
  rnid_t exp_rd  [DISP_SIZE];
  rnid_t exp_old [DISP_SIZE];
  rnid_t exp_rs1 [DISP_SIZE];
  rnid_t exp_rs2 [DISP_SIZE];

  logic   live;
  logic   fire;
  logic   cmt_on;                 // commits held back until the lists drain
  integer seed;
  int     groups;
  int     stall_cycles;
  int     fwd_hits;
  int     cycle_cnt = 0;

  rename_top uut (
    .i_clk         (i_clk),
    .i_reset_n     (i_reset_n),
    .i_disp_valid  (i_disp_valid),
    .o_disp_ready  (o_disp_ready),
    .i_rd_valid    (i_rd_valid),
    .i_rd_idx      (i_rd_idx),
    .i_rs1_idx     (i_rs1_idx),
    .i_rs2_idx     (i_rs2_idx),
    .o_valid       (o_valid),
    .o_rd_rnid     (o_rd_rnid),
    .o_rd_old_rnid (o_rd_old_rnid),
    .o_rs1_rnid    (o_rs1_rnid),
    .o_rs2_rnid    (o_rs2_rnid),
    .i_cmt_valid   (i_cmt_valid),
    .i_cmt_rnid    (i_cmt_rnid)
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycle_cnt++;
    if (cycle_cnt > TIMEOUT) begin
      abort_run($sformatf("timeout, run did not finish within %0d cycles", TIMEOUT));
    end
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_rnid(input string name, input rnid_t act, input rnid_t exp);
    if (act !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, act, exp);
      abort_run("renamed ID differs from the model");
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, act, exp);
      abort_run("control output differs from the model");
    end
  endtask

  // mostly low registers so lanes collide often
  function automatic arch_t random_idx();
    int rnd;
    rnd = $random(seed);
    if (rnd[8]) begin
      return arch_t'(rnd[2:0]);
    end
    return arch_t'(rnd[4:0]);
  endfunction

  task automatic model_reset();
    for (int i = 0; i < ARCH_REGS; i++) begin
      model_map[i] = rnid_t'(i);
    end
    for (int d = 0; d < DISP_SIZE; d++) begin
      free_q[d].delete();
      pend_q[d].delete();
      for (int k = 0; k < FLIST_SIZE; k++) begin
        free_q[d].push_back(rnid_t'(ARCH_REGS + FLIST_SIZE * d + k));
      end
    end
    push_d1 = '0;
    push_d2 = '0;
  endtask

  // lanes renamed in program order so later lanes see earlier writes
  task automatic model_fire();
    for (int d = 0; d < DISP_SIZE; d++) begin
      exp_rs1[d]    = model_map[i_rs1_idx[d]];
      exp_rs2[d]    = model_map[i_rs2_idx[d]];
      exp_old[d]    = model_map[i_rd_idx[d]];
      exp_chk_rd[d] = i_rd_valid[d];
      if (i_rd_valid[d] && (i_rd_idx[d] != '0)) begin
        exp_rd[d] = free_q[d].pop_front();
        model_map[i_rd_idx[d]] = exp_rd[d];
        pend_q[d].push_back(exp_old[d]);
      end else begin
        exp_rd[d] = X0_RNID;   // x0 keeps ID 0
      end
    end
    if (i_rd_valid[0] && (i_rd_idx[0] != '0) &&
        ((i_rs1_idx[1] == i_rd_idx[0]) || (i_rs2_idx[1] == i_rd_idx[0]))) begin
      fwd_hits++;
    end
    exp_valid = 1'b1;
  endtask

  task automatic check_group();
    for (int d = 0; d < DISP_SIZE; d++) begin
      check_rnid($sformatf("o_rs1_rnid[%0d]", d), o_rs1_rnid[d], exp_rs1[d]);
      check_rnid($sformatf("o_rs2_rnid[%0d]", d), o_rs2_rnid[d], exp_rs2[d]);
      if (exp_chk_rd[d]) begin
        check_rnid($sformatf("o_rd_rnid[%0d]", d), o_rd_rnid[d], exp_rd[d]);
        check_rnid($sformatf("o_rd_old_rnid[%0d]", d), o_rd_old_rnid[d], exp_old[d]);
      end
    end
  endtask

  // sample at the falling edge when inputs and outputs have settled
  task automatic check_cycle();
    logic exp_ready;
    @(negedge i_clk);
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (push_d2[d]) begin
        free_q[d].push_back(push_id_d2[d]);
      end
    end
    push_d2    = push_d1;
    push_id_d2 = push_id_d1;
    push_d1    = i_cmt_valid;
    push_id_d1 = i_cmt_rnid;

    check_bit("o_valid", o_valid, exp_valid);
    if (exp_valid) begin
      check_group();
    end
    exp_valid = 1'b0;

    exp_ready = live;
    for (int d = 0; d < DISP_SIZE; d++) begin
      if (free_q[d].size() == 0) begin
        exp_ready = 1'b0;
      end
    end
    check_bit("o_disp_ready", o_disp_ready, exp_ready);
    if (live && !exp_ready && !cmt_on) begin
      stall_cycles++;
      if (stall_cycles >= 4) begin
        cmt_on = 1'b1;   // start returning IDs once the lists have drained
      end
    end
    live = i_reset_n;

    fire = i_disp_valid && o_disp_ready;
    if (fire) begin
      model_fire();
      groups++;
    end
  endtask

  task automatic drive_inputs();
    int rnd;
    @(posedge i_clk);
    if (groups >= NUM_GROUPS) begin
      i_disp_valid <= 1'b0;
    end else if (!(i_disp_valid && !fire)) begin   // a waiting group stays put
      rnd = $random(seed);
      i_disp_valid <= (rnd[1:0] != 2'b00);
      for (int d = 0; d < DISP_SIZE; d++) begin
        rnd = $random(seed);
        i_rd_valid[d] <= (rnd[3:0] != 4'h0);
        i_rd_idx[d]   <= random_idx();
        i_rs1_idx[d]  <= random_idx();
        i_rs2_idx[d]  <= random_idx();
      end
    end
    for (int d = 0; d < DISP_SIZE; d++) begin
      rnd = $random(seed);
      if (cmt_on && (pend_q[d].size() > 0) && (rnd[1:0] != 2'b00)) begin
        i_cmt_valid[d] <= 1'b1;
        i_cmt_rnid[d]  <= pend_q[d].pop_front();
      end else begin
        i_cmt_valid[d] <= 1'b0;
        i_cmt_rnid[d]  <= '0;
      end
    end
  endtask

  initial begin
    seed         = 32'hf95deed7;
    groups       = 0;
    stall_cycles = 0;
    fwd_hits     = 0;
    live         = 1'b0;
    fire         = 1'b0;
    cmt_on       = 1'b0;
    exp_valid    = 1'b0;
    exp_chk_rd   = '0;
    i_reset_n    = 1'b0;
    i_disp_valid = 1'b0;
    i_rd_valid   = '0;
    i_cmt_valid  = '0;
    for (int d = 0; d < DISP_SIZE; d++) begin
      i_rd_idx[d]   = '0;
      i_rs1_idx[d]  = '0;
      i_rs2_idx[d]  = '0;
      i_cmt_rnid[d] = '0;
    end
    model_reset();

    repeat (5) @(posedge i_clk);
    i_reset_n <= 1'b1;

    while ((groups < NUM_GROUPS) || exp_valid) begin
      check_cycle();
      drive_inputs();
    end
    // no stray strobes once dispatch stops
    repeat (3) begin
      check_cycle();
      drive_inputs();
    end

    if (!cmt_on) begin
      abort_run("free lists never ran empty while commits were withheld");
    end else if (fwd_hits == 0) begin
      abort_run("no group exercised forwarding from lane 0 to lane 1");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule
